//--- list.f
+incdir+include
verilog/rename_pkg.sv
verilog/mapTable.sv
verilog/freeList.sv
verilog/reorderBuffer.sv
verilog/dispatchControl.sv
verilog/renameCore.sv
dv/renameCore_tb.sv

//--- Bender.yml
package:
  name: renameCore

export_include_dirs:
  - include

sources:
  - verilog/rename_pkg.sv
  - verilog/mapTable.sv
  - verilog/freeList.sv
  - verilog/reorderBuffer.sv
  - verilog/dispatchControl.sv
  - verilog/renameCore.sv
  - target: simulation
    files:
      - dv/renameCore_tb.sv

//--- dv/renameCore_tb.sv
/*
  testbench for the rename and retire top level
  LCG stimulus, reference model of map, free list and reorder buffer
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module renameCore_tb
  import rename_pkg::*;
();

  logic     clock;
  logic     reset;
  logic     dispatchReq;
  archReg_t dispatchDest;
  logic     dispatchAck;
  physReg_t newPhys;
  physReg_t oldPhys;
  robIdx_t  robIndex;
  logic     retire;
  logic     retireValid;
  physReg_t freedPhys;

  // reference model
  physReg_t modelMap [`NUM_ARCH];
  physReg_t modelFree [$];
  physReg_t modelT [$];
  physReg_t modelTOld [$];
  robIdx_t  modelIndex;
  // ack level at the previous sample, for edge detection
  logic     lastAck;
  // strobe hit a non-empty buffer, release expected next sample
  logic     releaseDue;
  logic [31:0] lcgState;
  int mismatchCount;
  int timeoutCount;
  int protocolCount;

  renameCore DUT (
    .clock        (clock),
    .reset        (reset),
    .dispatchReq  (dispatchReq),
    .dispatchDest (dispatchDest),
    .dispatchAck  (dispatchAck),
    .newPhys      (newPhys),
    .oldPhys      (oldPhys),
    .robIndex     (robIndex),
    .retire       (retire),
    .retireValid  (retireValid),
    .freedPhys    (freedPhys)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  function automatic logic [31:0] lcgNext();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  // 0 to 99, from the upper bits
  function automatic int percent();
    logic [31:0] r;
    r = lcgNext();
    return int'(r[30:16]) % 100;
  endfunction

  function automatic archReg_t drawDest();
    logic [31:0] r;
    r = lcgNext();
    return archReg_t'(r[27:23]);
  endfunction

  task automatic checkPhys(input physReg_t actual, input physReg_t expected, input string what);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkIndex(input robIdx_t actual, input robIdx_t expected, input string what);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic checkFlag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      mismatchCount++;
      $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  // sample at the falling edge, update the model, then drive retire
  task automatic stepCycle(input logic strobe);
    @(negedge clock);
    checkFlag(retireValid, releaseDue, "retireValid");
    if (retireValid && releaseDue) begin
      // oldest entry hands T_old back to the free list tail
      checkPhys(freedPhys, modelTOld[0], "freedPhys");
      modelFree.push_back(modelTOld.pop_front());
      void'(modelT.pop_front());
    end
    if (dispatchAck && !lastAck) begin
      // entry written at the same edge that raised ack
      checkPhys(newPhys, modelFree[0], "newPhys");
      checkPhys(oldPhys, modelMap[dispatchDest], "oldPhys");
      checkIndex(robIndex, modelIndex, "robIndex");
      modelT.push_back(modelFree[0]);
      modelTOld.push_back(modelMap[dispatchDest]);
      modelMap[dispatchDest] = modelFree.pop_front();
      modelIndex = modelIndex + 1'b1;
    end
    lastAck    = dispatchAck;
    retire     = strobe;
    releaseDue = strobe && (modelT.size() > 0);
  endtask

  // retire strobe in about 40% of cycles when enabled
  task automatic stepRandom(input bit enable);
    stepCycle(enable && (percent() < 40));
  endtask

  task automatic raiseRequest(input archReg_t dest);
    dispatchReq  = 1'b1;
    dispatchDest = dest;
  endtask

  task automatic waitAck(input bit randomRetire, input int limit);
    int waited;
    waited = 0;
    while (!dispatchAck && waited < limit) begin
      stepRandom(randomRetire);
      waited++;
    end
    if (!dispatchAck) begin
      timeoutCount++;
      $display("timeout at %0t: no dispatch acknowledge within %0d cycles", $time, limit);
    end
  endtask

  // return to zero, ack must follow the request low
  task automatic dropRequest(input bit randomRetire);
    int waited;
    dispatchReq = 1'b0;
    waited = 0;
    while (dispatchAck && waited < 10) begin
      stepRandom(randomRetire);
      waited++;
    end
    if (dispatchAck) begin
      timeoutCount++;
      $display("timeout at %0t: dispatch acknowledge stayed high after request fell", $time);
    end
  endtask

  task automatic dispatchOne(input archReg_t dest, input bit randomRetire);
    raiseRequest(dest);
    waitAck(randomRetire, 200);
    dropRequest(randomRetire);
  endtask

  initial begin
    archReg_t firstDest;
    reset         = 1'b1;
    dispatchReq   = 1'b0;
    dispatchDest  = '0;
    retire        = 1'b0;
    lcgState      = 32'd20;
    mismatchCount = 0;
    timeoutCount  = 0;
    protocolCount = 0;
    lastAck       = 1'b0;
    releaseDue    = 1'b0;
    modelIndex    = '0;
    // identity map, upper half free in order
    for (int i = 0; i < `NUM_ARCH; i++) begin
      modelMap[i] = physReg_t'(i);
    end
    for (int i = `NUM_ARCH; i < `NUM_PR; i++) begin
      modelFree.push_back(physReg_t'(i));
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // strobe on an empty buffer, no release allowed
    stepCycle(1'b1);
    stepCycle(1'b0);

    // first dispatch gets tag 32 and the identity mapping
    firstDest = drawDest();
    raiseRequest(firstDest);
    waitAck(1'b0, 20);
    checkPhys(newPhys, physReg_t'(`NUM_ARCH), "first newPhys");
    checkPhys(oldPhys, physReg_t'(firstDest), "first oldPhys");
    checkIndex(robIndex, '0, "first robIndex");
    dropRequest(1'b0);

    // fill the buffer, no retires
    for (int i = 1; i < `NUM_ROB; i++) begin
      dispatchOne(drawDest(), 1'b0);
    end

    // ninth request stalls until a slot frees up
    raiseRequest(drawDest());
    repeat (10) begin
      stepCycle(1'b0);
      if (dispatchAck) begin
        protocolCount++;
        $display("error at %0t: dispatch acknowledged while the reorder buffer was full", $time);
      end
    end
    stepCycle(1'b1);
    waitAck(1'b0, 20);
    dropRequest(1'b0);

    // random traffic, retires overlap allocate cycles
    repeat (150) begin
      if (percent() < 50) begin
        dispatchOne(drawDest(), 1'b1);
      end else begin
        stepRandom(1'b1);
      end
    end

    // drain, then one more strobe on the empty buffer
    for (int i = 0; i < 20 && modelT.size() > 0; i++) begin
      stepCycle(1'b1);
    end
    stepCycle(1'b1);
    stepCycle(1'b0);
    stepCycle(1'b0);

    $display("errors: %0d mismatches, %0d timeouts, %0d protocol", mismatchCount,
             timeoutCount, protocolCount);
    if (mismatchCount + timeoutCount + protocolCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- verilog/renameCore.sv
/*
  rename and retire top level
  dispatch controller, map table, free list, reorder buffer
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module renameCore
  import rename_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     dispatchReq,
  input  archReg_t dispatchDest,
  output logic     dispatchAck,
  output physReg_t newPhys,
  output physReg_t oldPhys,
  output robIdx_t  robIndex,
  input  logic     retire,
  output logic     retireValid,
  output physReg_t freedPhys
);

  logic     allocate;
  logic     robFull;
  robIdx_t  tailIndex;
  // T from the free list head, T_old from the map table
  physReg_t headPhys;
  physReg_t mappedPhys;

  dispatchControl control (
    .clock       (clock),
    .reset       (reset),
    .dispatchReq (dispatchReq),
    .robFull     (robFull),
    .allocate    (allocate),
    .grantNew    (headPhys),
    .grantOld    (mappedPhys),
    .grantIndex  (tailIndex),
    .dispatchAck (dispatchAck),
    .newPhys     (newPhys),
    .oldPhys     (oldPhys),
    .robIndex    (robIndex)
  );

  // read old mapping and write the new tag in the same allocate cycle
  mapTable map (
    .clock       (clock),
    .reset       (reset),
    .readArch    (dispatchDest),
    .readPhys    (mappedPhys),
    .writeEnable (allocate),
    .writeArch   (dispatchDest),
    .writePhys   (headPhys)
  );

  // retired T_old goes straight back in
  freeList free (
    .clock    (clock),
    .reset    (reset),
    .pop      (allocate),
    .headPhys (headPhys),
    .push     (retireValid),
    .pushPhys (freedPhys)
  );

  reorderBuffer rob (
    .clock        (clock),
    .reset        (reset),
    .allocate     (allocate),
    .allocT       (headPhys),
    .allocTOld    (mappedPhys),
    .tailIndex    (tailIndex),
    .full         (robFull),
    .retire       (retire),
    .releaseValid (retireValid),
    .releasePhys  (freedPhys)
  );

endmodule

//--- verilog/dispatchControl.sv
/*
  four-phase dispatch handshake controller
  one-cycle allocate pulse, results held while ack is high
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module dispatchControl
  import rename_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     dispatchReq,
  input  logic     robFull,
  output logic     allocate,
  input  physReg_t grantNew,
  input  physReg_t grantOld,
  input  robIdx_t  grantIndex,
  output logic     dispatchAck,
  output physReg_t newPhys,
  output physReg_t oldPhys,
  output robIdx_t  robIndex
);

  dispatchState_t state;
  dispatchState_t nextState;

  always_comb begin
    nextState = state;
    case (state)
      // wait for request and a free rob slot, no limit on the wait
      IDLE: begin
        if (dispatchReq && !robFull) begin
          nextState = GRANT;
        end
      end
      // allocate cycle, results captured at the edge
      GRANT: nextState = ACK;
      // ack high until the requester lets go
      ACK: begin
        if (!dispatchReq) begin
          nextState = DROP;
        end
      end
      // ack back low, return to zero done
      DROP: nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  assign allocate    = (state == GRANT);
  assign dispatchAck = (state == ACK);

  // holding registers, valid while ack is high
  always_ff @(posedge clock) begin
    if (state == GRANT) begin
      newPhys  <= grantNew;
      oldPhys  <= grantOld;
      robIndex <= grantIndex;
    end
  end

  // one rob entry per handshake
  singleAlloc: assert property (
    @(posedge clock) disable iff (reset)
    allocate |=> !allocate
  ) else $error("allocate held longer than one cycle");

endmodule

//--- verilog/reorderBuffer.sv
/*
  circular queue of in-flight instructions
  each entry keeps the new tag T and the replaced tag T_old
  retirement hands T_old back to the free list
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module reorderBuffer
  import rename_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     allocate,
  input  physReg_t allocT,
  input  physReg_t allocTOld,
  output robIdx_t  tailIndex,
  output logic     full,
  input  logic     retire,
  output logic     releaseValid,
  output physReg_t releasePhys
);

  // per-entry state
  logic     entryValid [`NUM_ROB];
  physReg_t entryT     [`NUM_ROB];
  physReg_t entryTOld  [`NUM_ROB];

  // head marks the oldest instruction and tail the next free slot
  robIdx_t headPtr;
  robIdx_t tailPtr;

  logic empty;
  logic writeTail;
  logic moveHead;

  // tail slot still occupied means the queue wrapped onto the head
  assign full      = entryValid[tailPtr];
  assign empty     = !entryValid[headPtr];
  assign tailIndex = tailPtr;

  // both use the state at the start of the cycle
  assign writeTail = allocate && !full;
  assign moveHead  = retire && !empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      headPtr      <= '0;
      tailPtr      <= '0;
      releaseValid <= 1'b0;
      for (int i = 0; i < `NUM_ROB; i++) begin
        entryValid[i] <= 1'b0;
      end
    end else begin
      releaseValid <= moveHead;
      // retire frees the head slot
      if (moveHead) begin
        entryValid[headPtr] <= 1'b0;
        headPtr             <= headPtr + 1'b1;
      end
      // head and tail differ whenever both fire
      if (writeTail) begin
        entryValid[tailPtr] <= 1'b1;
        tailPtr             <= tailPtr + 1'b1;
      end
    end
  end

  // T and T_old written at the tail, T_old read out at the head
  always_ff @(posedge clock) begin
    if (writeTail) begin
      entryT[tailPtr]    <= allocT;
      entryTOld[tailPtr] <= allocTOld;
    end
    if (moveHead) begin
      releasePhys <= entryTOld[headPtr];
    end
  end

  // controller holds off while full
  noAllocFull: assert property (
    @(posedge clock) disable iff (reset)
    allocate |-> !full
  ) else $error("allocate while reorder buffer full");

  // a retiring instruction must not free the tag it still owns
  distinctRetire: assert property (
    @(posedge clock) disable iff (reset)
    moveHead |-> (entryT[headPtr] != entryTOld[headPtr])
  ) else $error("retiring entry %0d frees its own tag", headPtr);

endmodule

//--- verilog/freeList.sv
/*
  FIFO of unused physical registers
  pop on dispatch, push of freed tags on retirement
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module freeList
  import rename_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     pop,
  output physReg_t headPhys,
  input  logic     push,
  input  physReg_t pushPhys
);

  // one slot per physical register, so it can never overflow in use
  physReg_t slots [`NUM_PR];

  // pointers wrap naturally at NUM_PR
  physReg_t headPtr;
  physReg_t tailPtr;

  // 0 to NUM_PR inclusive
  logic [$clog2(`NUM_PR):0] count;

  // head visible before the pop edge
  assign headPhys = slots[headPtr];

  always_ff @(posedge clock) begin
    if (reset) begin
      // registers above the arch range start out free, in order
      for (int i = 0; i < `NUM_PR - `NUM_ARCH; i++) begin
        slots[i] <= physReg_t'(i + `NUM_ARCH);
      end
      headPtr <= '0;
      tailPtr <= physReg_t'(`NUM_PR - `NUM_ARCH);
      count   <= ($clog2(`NUM_PR) + 1)'(`NUM_PR - `NUM_ARCH);
    end else begin
      if (pop) begin
        headPtr <= headPtr + 1'b1;
      end
      // pushed tag lands at the tail, behind the popped head
      if (push) begin
        slots[tailPtr] <= pushPhys;
        tailPtr        <= tailPtr + 1'b1;
      end
      // net occupancy change
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  // rob depth keeps at least NUM_PR - NUM_ARCH - NUM_ROB tags free
  noUnderflow: assert property (
    @(posedge clock) disable iff (reset)
    pop |-> (count != '0)
  ) else $error("free list popped while empty");

  // only tags handed out earlier come back
  noOverflow: assert property (
    @(posedge clock) disable iff (reset)
    push |-> (count != ($clog2(`NUM_PR) + 1)'(`NUM_PR))
  ) else $error("free list pushed while full");

endmodule

//--- verilog/mapTable.sv
/*
  architectural to physical register map
  combinational read port, clocked write port
*/

`timescale 1ns/1ps

`include "rename_defines.svh"

module mapTable
  import rename_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  archReg_t readArch,
  output physReg_t readPhys,
  input  logic     writeEnable,
  input  archReg_t writeArch,
  input  physReg_t writePhys
);

  // one tag per architectural register
  physReg_t mapping [`NUM_ARCH];

  // old mapping must be visible in the allocate cycle
  assign readPhys = mapping[readArch];

  always_ff @(posedge clock) begin
    if (reset) begin
      // arch i starts out in phys i
      for (int i = 0; i < `NUM_ARCH; i++) begin
        mapping[i] <= physReg_t'(i);
      end
    end else if (writeEnable) begin
      mapping[writeArch] <= writePhys;
    end
  end

  // new tag comes from the free list, so it cannot be the live one
  // a match means the free list handed out a mapped register
  freshTag: assert property (
    @(posedge clock) disable iff (reset)
    writeEnable |-> (writePhys != mapping[writeArch])
  ) else $error("map table rewrote entry %0d with its own tag %0d", writeArch, writePhys);

endmodule

//--- verilog/rename_pkg.sv
/*
  shared types for the rename subsystem
  tag and index vectors, dispatch controller states
*/

`include "rename_defines.svh"

package rename_pkg;

  // physical register tag
  typedef logic [$clog2(`NUM_PR)-1:0] physReg_t;

  // architectural register number
  typedef logic [$clog2(`NUM_ARCH)-1:0] archReg_t;

  // reorder buffer slot
  typedef logic [$clog2(`NUM_ROB)-1:0] robIdx_t;

  // four-phase dispatch handshake states
  typedef enum logic [1:0] {IDLE, GRANT, ACK, DROP} dispatchState_t;

endpackage

//--- include/rename_defines.svh
/*
  size constants for the rename subsystem
  physical, architectural and reorder buffer counts
*/

`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// physical register file depth
`define NUM_PR 64

// architectural registers, identity mapped at reset
`define NUM_ARCH 32

// in-flight instruction limit
`define NUM_ROB 8

`endif
